//--- design/shift_pkg.sv
package shift_pkg;

  localparam int DATA_W = 32;
  localparam int CNT_W  = 5;
  localparam int FLAG_W = 6;

  localparam int FLAG_CF = 0;
  localparam int FLAG_PF = 1;
  localparam int FLAG_AF = 2;
  localparam int FLAG_ZF = 3;
  localparam int FLAG_SF = 4;
  localparam int FLAG_OF = 5;

  typedef enum logic [1:0] {OP_SHL = 2'd0, OP_SHR = 2'd1, OP_SAR = 2'd2} shift_op_t;
  typedef enum logic [1:0] {SIZE_8 = 2'd0, SIZE_16 = 2'd1, SIZE_32 = 2'd2} op_size_t;

  typedef logic [FLAG_W-1:0] flags_t;

  typedef struct packed {
    logic [DATA_W-1:0] result;
    logic              carry;
  } shift_out_t;

  // Keeps only the bits of the selected operand size.
  function automatic logic [DATA_W-1:0] size_mask(op_size_t size);
    case (size)
      SIZE_8:  return 32'h0000_00ff;
      SIZE_16: return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  function automatic logic [CNT_W:0] size_width(op_size_t size);
    case (size)
      SIZE_8:  return 6'd8;
      SIZE_16: return 6'd16;
      default: return 6'd32;
    endcase
  endfunction

  // Top bit of a value at the selected operand size.
  function automatic logic size_msb(logic [DATA_W-1:0] value, op_size_t size);
    case (size)
      SIZE_8:  return value[7];
      SIZE_16: return value[15];
      default: return value[31];
    endcase
  endfunction

endpackage

//--- design/shift_if.sv
`timescale 1ns/1ps

interface shift_req_if import shift_pkg::*; (input logic clk);

  logic              valid;    // One-cycle request strobe.
  shift_op_t         op;
  op_size_t          size;
  logic [DATA_W-1:0] operand;
  logic [CNT_W-1:0]  count;    // Already masked to five bits.
  flags_t            flags_in;

  modport source (
    output valid,
    output op,
    output size,
    output operand,
    output count,
    output flags_in
  );

  modport sink (
    input clk,
    input valid,
    input op,
    input size,
    input operand,
    input count,
    input flags_in
  );

endinterface

//--- design/shift_left_unit.sv
`timescale 1ns/1ps

module shift_left_unit import shift_pkg::*; (
  shift_req_if.sink  req,
  output shift_out_t left_out
);

  logic [DATA_W-1:0] sized;
  logic [DATA_W:0]   stage [CNT_W+1];   // Bit DATA_W catches what leaves the 32-bit word.
  logic              carry;

  assign sized    = req.operand & size_mask(req.size);
  assign stage[0] = {1'b0, sized};

  // Five levels, largest step first: 16, 8, 4, 2, 1.
  genvar j;
  generate
    for (j = 0; j < CNT_W; j++) begin : gen_level
      localparam int AMT = 1 << (CNT_W - 1 - j);

      assign stage[j+1] = req.count[CNT_W-1-j] ?
                          {stage[j][DATA_W-AMT:0], {AMT{1'b0}}} : stage[j];
    end
  endgenerate

  // The bit just above the top of the size is the last one shifted out.
  // A count past the size width only brings zeros up to that position.
  always_comb begin
    case (req.size)
      SIZE_8:  carry = stage[CNT_W][8];
      SIZE_16: carry = stage[CNT_W][16];
      default: carry = stage[CNT_W][DATA_W];
    endcase
  end

  assign left_out.result = stage[CNT_W][DATA_W-1:0] & size_mask(req.size);
  assign left_out.carry  = carry;

  // The decoder upstream must never issue the unused size code.
  a_legal_size: assert property (
    @(posedge req.clk) req.valid |-> req.size inside {SIZE_8, SIZE_16, SIZE_32}
  ) else $error("shift request with illegal operand size");

endmodule

//--- design/shift_right_unit.sv
`timescale 1ns/1ps

module shift_right_unit import shift_pkg::*; (
  shift_req_if.sink  req,
  output shift_out_t right_out
);

  logic [DATA_W-1:0] mask;
  logic [DATA_W-1:0] sized;
  logic [DATA_W-1:0] extended;
  logic [CNT_W:0]    width;
  logic              is_sar;
  logic              fill;
  logic [CNT_W-1:0]  eff_cnt;
  logic [DATA_W:0]   stage [CNT_W+1];   // Bit 0 is a guard that catches the carry.

  assign mask   = size_mask(req.size);
  assign sized  = req.operand & mask;
  assign width  = size_width(req.size);
  assign is_sar = (req.op == OP_SAR);
  assign fill   = is_sar & size_msb(req.operand, req.size);  // Sign for SAR, zero for SHR.

  // Bits above the size already hold the fill, so it enters at the size's top bit.
  assign extended = sized | ({DATA_W{fill}} & ~mask);

  // SAR saturates at the size width: the result is all sign and the carry is the sign.
  always_comb begin
    eff_cnt = req.count;
    if (is_sar && ({1'b0, req.count} > width)) begin
      eff_cnt = width[CNT_W-1:0];
    end
  end

  assign stage[0] = {extended, 1'b0};

  genvar j;
  generate
    for (j = 0; j < CNT_W; j++) begin : gen_level
      localparam int AMT = 1 << (CNT_W - 1 - j);

      assign stage[j+1] = eff_cnt[CNT_W-1-j] ?
                          {{AMT{fill}}, stage[j][DATA_W:AMT]} : stage[j];
    end
  endgenerate

  assign right_out.result = stage[CNT_W][DATA_W:1] & mask;  // Zero above the size.
  assign right_out.carry  = stage[CNT_W][0];                 // Last bit out of bit 0.

endmodule

//--- design/shift_flag_merge.sv
`timescale 1ns/1ps

module shift_flag_merge import shift_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  shift_req_if.sink         req,
  input  shift_out_t        left_out,
  input  shift_out_t        right_out,
  output logic              res_valid,
  output logic [DATA_W-1:0] result,
  output flags_t            flags_out
);

  shift_out_t        sel;
  logic [DATA_W-1:0] sized_operand;
  logic              zero_cnt;
  logic              one_cnt;
  logic              res_msb;
  flags_t            shift_flags;
  logic [DATA_W-1:0] result_d;
  flags_t            flags_d;

  assign sel           = (req.op == OP_SHL) ? left_out : right_out;
  assign sized_operand = req.operand & size_mask(req.size);
  assign zero_cnt      = (req.count == '0);
  assign one_cnt       = (req.count == CNT_W'(1));
  assign res_msb       = size_msb(sel.result, req.size);

  always_comb begin
    shift_flags          = '0;
    shift_flags[FLAG_CF] = sel.carry;
    shift_flags[FLAG_PF] = ~^sel.result[7:0];   // Parity looks at the low byte only.
    shift_flags[FLAG_AF] = 1'b0;
    shift_flags[FLAG_ZF] = (sel.result == '0);  // Result is already zero above the size.
    shift_flags[FLAG_SF] = res_msb;
    if (one_cnt) begin
      case (req.op)
        OP_SHL:  shift_flags[FLAG_OF] = res_msb ^ sel.carry;
        OP_SHR:  shift_flags[FLAG_OF] = size_msb(req.operand, req.size);
        default: shift_flags[FLAG_OF] = 1'b0;
      endcase
    end
  end

  // A masked count of zero leaves the operand and the flags untouched.
  assign result_d = zero_cnt ? sized_operand : sel.result;
  assign flags_d  = zero_cnt ? req.flags_in : shift_flags;

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid <= 1'b0;
      result    <= '0;
      flags_out <= '0;
    end else begin
      res_valid <= req.valid;
      if (req.valid) begin
        result    <= result_d;
        flags_out <= flags_d;
      end
    end
  end

  a_valid_latency: assert property (
    @(posedge clk) disable iff (reset) req.valid |=> res_valid
  ) else $error("res_valid missing one cycle after a request");

  a_no_spurious_valid: assert property (
    @(posedge clk) disable iff (reset) !req.valid |=> !res_valid
  ) else $error("res_valid without a request");

  // flags_in may carry AF through a zero count, but a real shift always clears it.
  a_af_clear: assert property (
    @(posedge clk) disable iff (reset)
    res_valid && ($past(req.count) != '0) |-> !flags_out[FLAG_AF]
  ) else $error("AF set by a shift");

endmodule

//--- design/shift_exec_top.sv
`timescale 1ns/1ps

module shift_exec_top import shift_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              op_valid,
  input  shift_op_t         op_kind,
  input  op_size_t          op_size,
  input  logic [DATA_W-1:0] operand,
  input  logic [7:0]        count,
  input  flags_t            flags_in,
  output logic              res_valid,
  output logic [DATA_W-1:0] result,
  output flags_t            flags_out
);

  shift_out_t left_out;
  shift_out_t right_out;

  shift_req_if req_if (.clk(clk));

  assign req_if.valid    = op_valid;
  assign req_if.op       = op_kind;
  assign req_if.size     = op_size;
  assign req_if.operand  = operand;
  assign req_if.count    = count[CNT_W-1:0];  // x86 masks the count to five bits.
  assign req_if.flags_in = flags_in;

  shift_left_unit u_left (
    .req      (req_if.sink),
    .left_out (left_out)
  );

  shift_right_unit u_right (
    .req       (req_if.sink),
    .right_out (right_out)
  );

  shift_flag_merge u_merge (
    .clk       (clk),
    .reset     (reset),
    .req       (req_if.sink),
    .left_out  (left_out),
    .right_out (right_out),
    .res_valid (res_valid),
    .result    (result),
    .flags_out (flags_out)
  );

endmodule

//--- test/shift_exec_tb.sv
`timescale 1ns/1ps

module shift_exec_tb import shift_pkg::*; ();

  localparam int NUM_DIRECTED = 25;
  localparam int NUM_RANDOM   = 64;
  localparam int CYCLE_LIMIT  = 2 * (NUM_DIRECTED + NUM_RANDOM) + 20;

  typedef struct packed {
    shift_op_t         op;
    op_size_t          size;
    logic [DATA_W-1:0] operand;
    logic [7:0]        count;
    flags_t            flags_in;
    logic [DATA_W-1:0] exp_result;
    flags_t            exp_flags;   // OF SF ZF AF PF CF from bit 5 down.
  } vec_t;

  vec_t dir_tab [NUM_DIRECTED] = '{
    '{OP_SHL, SIZE_8,  32'habcd_0081, 8'd1,  6'h3f, 32'h0000_0002, 6'b100001},
    '{OP_SHL, SIZE_8,  32'h0000_00c1, 8'd7,  6'h00, 32'h0000_0080, 6'b010000},
    '{OP_SHL, SIZE_8,  32'h0000_00c1, 8'd8,  6'h00, 32'h0000_0000, 6'b001011},
    '{OP_SHL, SIZE_8,  32'h0000_00ff, 8'd9,  6'h3f, 32'h0000_0000, 6'b001010},
    '{OP_SHL, SIZE_16, 32'h1234_c001, 8'd1,  6'h00, 32'h0000_8002, 6'b010001},
    '{OP_SHL, SIZE_16, 32'h0000_0003, 8'd15, 6'h00, 32'h0000_8000, 6'b010011},
    '{OP_SHL, SIZE_16, 32'h0000_8001, 8'd16, 6'h00, 32'h0000_0000, 6'b001011},
    '{OP_SHL, SIZE_16, 32'h0000_ffff, 8'd17, 6'h3f, 32'h0000_0000, 6'b001010},
    '{OP_SHL, SIZE_32, 32'h4000_0001, 8'd1,  6'h00, 32'h8000_0002, 6'b110000},
    '{OP_SHL, SIZE_32, 32'h0000_0003, 8'd31, 6'h00, 32'h8000_0000, 6'b010011},
    '{OP_SHL, SIZE_32, 32'h8000_0000, 8'd33, 6'h00, 32'h0000_0000, 6'b101011},
    '{OP_SHR, SIZE_8,  32'h0000_0081, 8'd1,  6'h3f, 32'h0000_0040, 6'b100001},
    '{OP_SAR, SIZE_8,  32'h0000_0081, 8'd1,  6'h3f, 32'h0000_00c0, 6'b010011},
    '{OP_SAR, SIZE_8,  32'h0000_0081, 8'd7,  6'h00, 32'h0000_00ff, 6'b010010},
    '{OP_SHR, SIZE_8,  32'h0000_0081, 8'd8,  6'h00, 32'h0000_0000, 6'b001011},
    '{OP_SAR, SIZE_8,  32'h0000_0081, 8'd12, 6'h00, 32'h0000_00ff, 6'b010011},
    '{OP_SAR, SIZE_8,  32'h0000_007f, 8'd12, 6'h00, 32'h0000_0000, 6'b001010},
    '{OP_SHR, SIZE_16, 32'hffff_8003, 8'd1,  6'h00, 32'h0000_4001, 6'b100001},
    '{OP_SAR, SIZE_16, 32'h0000_8003, 8'd1,  6'h00, 32'h0000_c001, 6'b010001},
    '{OP_SAR, SIZE_16, 32'h0000_8000, 8'd20, 6'h00, 32'h0000_ffff, 6'b010011},
    '{OP_SHR, SIZE_32, 32'h8000_0001, 8'd1,  6'h00, 32'h4000_0000, 6'b100011},
    '{OP_SAR, SIZE_32, 32'h8000_0001, 8'd31, 6'h00, 32'hffff_ffff, 6'b010010},
    '{OP_SHL, SIZE_16, 32'hdead_beef, 8'd0,  6'h3f, 32'h0000_beef, 6'b111111},
    '{OP_SAR, SIZE_8,  32'h1234_5680, 8'd32, 6'h15, 32'h0000_0080, 6'b010101},
    '{OP_SHR, SIZE_32, 32'hcafe_f00d, 8'd64, 6'h2a, 32'hcafe_f00d, 6'b101010}
  };

  logic              clk;
  logic              reset;
  logic              op_valid;
  shift_op_t         op_kind;
  op_size_t          op_size;
  logic [DATA_W-1:0] operand;
  logic [7:0]        count;
  flags_t            flags_in;
  logic              res_valid;
  logic [DATA_W-1:0] result;
  flags_t            flags_out;

  logic              exp_valid;
  logic [DATA_W-1:0] exp_res_q [$];
  flags_t            exp_flags_q [$];
  string             name_q [$];
  logic [31:0]       lfsr_state;
  int                mismatch_errs;
  int                other_errs;
  int                cycles;

  shift_exec_top u_dut (
    .clk       (clk),
    .reset     (reset),
    .op_valid  (op_valid),
    .op_kind   (op_kind),
    .op_size   (op_size),
    .operand   (operand),
    .count     (count),
    .flags_in  (flags_in),
    .res_valid (res_valid),
    .result    (result),
    .flags_out (flags_out)
  );

  always #50 clk = ~clk;

  task automatic check_result(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      mismatch_errs++;
      $display("CHECK FAILED %s result: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flags(input string name, input flags_t exp, input flags_t act);
    if (act !== exp) begin
      mismatch_errs++;
      $display("CHECK FAILED %s flags: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatch_errs++;
      $display("CHECK FAILED %s res_valid: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Shifts one bit at a time, straight from the x86 rules.
  function automatic void shift_model(input shift_op_t op, input op_size_t size,
                                      input logic [DATA_W-1:0] opd, input logic [7:0] cnt,
                                      input flags_t fin, output logic [DATA_W-1:0] res,
                                      output flags_t fl);
    int                w;
    int                n;
    int                i;
    logic [DATA_W-1:0] m;
    logic [DATA_W-1:0] v;
    logic [DATA_W-1:0] top;
    logic              c;
    logic              sign;
    w = (size == SIZE_8) ? 8 : (size == SIZE_16) ? 16 : 32;
    m = (w == 32) ? 32'hffff_ffff : ((32'h1 << w) - 32'h1);
    top = 32'h1 << (w - 1);
    n = int'(cnt[4:0]);
    v = opd & m;
    sign = v[w-1];
    c = 1'b0;
    res = v;
    fl = fin;
    if (n != 0) begin
      for (i = 0; i < n; i++) begin
        case (op)
          OP_SHL: begin
            c = v[w-1];
            v = (v << 1) & m;
          end
          OP_SHR: begin
            c = v[0];
            v = v >> 1;
          end
          default: begin
            c = v[0];
            v = (v >> 1) | (sign ? top : 32'h0);
          end
        endcase
      end
      res = v;
      fl = '0;
      fl[FLAG_CF] = c;
      fl[FLAG_PF] = ~^v[7:0];
      fl[FLAG_ZF] = (v == 32'h0);
      fl[FLAG_SF] = v[w-1];
      if (n == 1) begin
        case (op)
          OP_SHL:  fl[FLAG_OF] = v[w-1] ^ c;
          OP_SHR:  fl[FLAG_OF] = sign;
          default: fl[FLAG_OF] = 1'b0;
        endcase
      end
    end
  endfunction

  // Galois LFSR, one step for every bit handed out.
  function automatic logic [31:0] take_bits(input int n);
    int          i;
    logic [31:0] val;
    val = '0;
    for (i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  task automatic send(input vec_t v, input string name);
    @(posedge clk);
    #1;
    op_valid = 1'b1;
    op_kind  = v.op;
    op_size  = v.size;
    operand  = v.operand;
    count    = v.count;
    flags_in = v.flags_in;
    exp_res_q.push_back(v.exp_result);
    exp_flags_q.push_back(v.exp_flags);
    name_q.push_back(name);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    op_valid = 1'b0;
  endtask

  always @(posedge clk) begin
    exp_valid <= reset ? 1'b0 : op_valid;   // Latency of one cycle.
  end

  always @(negedge clk) begin
    string nm;
    if (!reset) begin
      check_valid("pulse timing", exp_valid, res_valid);
      if (res_valid) begin
        if (exp_res_q.size() == 0) begin
          other_errs++;
          $display("res_valid rose with no request outstanding");
        end else begin
          nm = name_q.pop_front();
          check_result(nm, exp_res_q.pop_front(), result);
          check_flags(nm, exp_flags_q.pop_front(), flags_out);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout after %0d cycles with %0d results missing", cycles, exp_res_q.size());
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    vec_t        v;
    logic [31:0] bits;
    logic [1:0]  b2;
    clk = 1'b0;
    reset = 1'b1;
    op_valid = 1'b0;
    op_kind = OP_SHL;
    op_size = SIZE_8;
    operand = '0;
    count = '0;
    flags_in = '0;
    lfsr_state = 32'd83521;
    mismatch_errs = 0;
    other_errs = 0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_valid("after reset", 1'b0, res_valid);
    check_result("after reset", '0, result);
    check_flags("after reset", '0, flags_out);

    for (int i = 0; i < NUM_DIRECTED; i++) begin   // Back to back, one request per cycle.
      send(dir_tab[i], $sformatf("directed %0d", i));
    end
    idle_cycle();

    for (int i = 0; i < NUM_RANDOM; i++) begin
      bits = take_bits(1);
      if (bits[0]) begin
        idle_cycle();   // Gaps between some requests.
      end
      bits = take_bits(2);
      b2 = bits[1:0] % 2'd3;
      v.op = shift_op_t'(b2);
      bits = take_bits(2);
      b2 = bits[1:0] % 2'd3;
      v.size = op_size_t'(b2);
      bits = take_bits(32);
      v.operand = bits;
      bits = take_bits(8);
      v.count = bits[7:0];
      bits = take_bits(6);
      v.flags_in = bits[5:0];
      shift_model(v.op, v.size, v.operand, v.count, v.flags_in, v.exp_result, v.exp_flags);
      send(v, $sformatf("random %0d", i));
    end
    idle_cycle();

    while (exp_res_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);

    $display("errors: %0d value mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- list.f
design/shift_pkg.sv
design/shift_if.sv
design/shift_left_unit.sv
design/shift_right_unit.sv
design/shift_flag_merge.sv
design/shift_exec_top.sv
test/shift_exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the shift unit testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f list.f --top-module shift_exec_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vshift_exec_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
exit 0
